/* rtl/memctrl_cfg.svh */
`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// IO window starts here and runs to the top of the address space
`define MEMCTRL_IO_BASE 32'h0003_0000

// byte address bits decoded by the RAM
`define MEMCTRL_RAM_AW 16

// bytes per instruction fetch
`define MEMCTRL_FETCH_LEN 4

`endif

/* rtl/memctrl_pkg.sv */
package memctrl_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;

    // access length in bytes, 1 2 or 4
    typedef logic [2:0]  len_t;
    // byte index inside one transaction
    typedef logic [2:0]  stage_t;

    // single byte access from one sequencer
    typedef struct packed {
        logic  valid;
        logic  write;
        logic  last;    // final byte issue of the transaction
        addr_t addr;
        byte_t wdata;
    } ramReq_t;

    typedef struct packed {
        logic  valid;
        byte_t rdata;
    } ramRsp_t;

    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } owner_e;

    typedef enum logic [1:0] {
        seqIdle,
        seqIssue,
        seqDrain
    } seqState_e;

endpackage

/* rtl/fetchSeq.sv */
`timescale 1ns/1ns
`include "memctrl_cfg.svh"

module fetchSeq (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 fetchEn,
    input  memctrl_pkg::addr_t   fetchAddr,
    output logic                 fetchDone,
    output memctrl_pkg::word_t   fetchInst,
    input  logic                 grant,
    output memctrl_pkg::ramReq_t req,
    input  memctrl_pkg::ramRsp_t rsp
);
    import memctrl_pkg::*;

    localparam stage_t lastStage = stage_t'(`MEMCTRL_FETCH_LEN - 1);
    localparam stage_t fullCount = stage_t'(`MEMCTRL_FETCH_LEN);

    seqState_e state;
    addr_t     baseAddr;
    stage_t    stage;
    stage_t    rcvIdx;
    logic      start;
    logic      issued;
    logic      allIn;

    // no new fetch in the done cycle, fetchEn is still up then
    assign start  = rdy && state == seqIdle && fetchEn && !fetchDone;
    assign issued = grant && req.valid && rdy;
    // last byte arriving now or already stored during a pause
    assign allIn  = (rsp.valid && rcvIdx == lastStage) || rcvIdx == fullCount;

    always_comb begin
        req       = '0;
        req.valid = state == seqIssue;
        req.write = 1'b0;
        req.last  = stage == lastStage;
        req.addr  = baseAddr + addr_t'(stage);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= seqIdle;
            stage     <= '0;
            rcvIdx    <= '0;
            fetchDone <= 1'b0;
        end else begin
            fetchDone <= 1'b0;
            // a read byte is on the bus for one cycle only
            if (rsp.valid) begin
                rcvIdx <= rcvIdx + 3'd1;
            end
            if (rdy) begin
                case (state)
                    seqIdle: begin
                        if (start) begin
                            state  <= seqIssue;
                            stage  <= '0;
                            rcvIdx <= '0;
                        end
                    end
                    seqIssue: begin
                        if (issued) begin
                            stage <= stage + 3'd1;
                            if (req.last) begin
                                state <= seqDrain;
                            end
                        end
                    end
                    seqDrain: begin
                        if (allIn) begin
                            state     <= seqIdle;
                            fetchDone <= 1'b1;
                        end
                    end
                    default: state <= seqIdle;
                endcase
            end
        end
    end

    // little-endian assembly straight into the output word
    always_ff @(posedge clk) begin
        if (start) begin
            baseAddr <= fetchAddr;
        end
        if (rsp.valid) begin
            fetchInst[{rcvIdx[1:0], 3'b000} +: 8] <= rsp.rdata;
        end
    end

endmodule

/* rtl/dataSeq.sv */
`timescale 1ns/1ns
`include "memctrl_cfg.svh"

module dataSeq (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  logic                 dataEn,
    input  logic                 dataStore,
    input  memctrl_pkg::len_t    dataLen,
    input  memctrl_pkg::addr_t   dataAddr,
    input  memctrl_pkg::word_t   dataWdata,
    output logic                 dataDone,
    output memctrl_pkg::word_t   dataRdata,
    input  logic                 grant,
    output memctrl_pkg::ramReq_t req,
    input  memctrl_pkg::ramRsp_t rsp
);
    import memctrl_pkg::*;

    seqState_e state;
    addr_t     baseAddr;
    addr_t     curAddr;
    len_t      lenReg;
    word_t     wdataReg;
    logic      isStore;
    stage_t    stage;
    stage_t    rcvIdx;
    stage_t    lastStage;
    logic      start;
    logic      issued;
    logic      ioStall;
    logic      allIn;

    assign start     = rdy && state == seqIdle && dataEn && !dataDone;
    assign lastStage = stage_t'(lenReg - 3'd1);
    assign curAddr   = baseAddr + addr_t'(stage);

    // stores into the IO window wait for room in the IO buffer
    assign ioStall = isStore && ioBufferFull && curAddr >= `MEMCTRL_IO_BASE;
    assign issued  = grant && req.valid && rdy;
    assign allIn   = (rsp.valid && rcvIdx == lastStage) || rcvIdx == stage_t'(lenReg);

    always_comb begin
        req       = '0;
        req.valid = state == seqIssue && !ioStall;
        req.write = isStore;
        req.last  = stage == lastStage;
        req.addr  = curAddr;
        // one byte lane per stage
        req.wdata = wdataReg[{stage[1:0], 3'b000} +: 8];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= seqIdle;
            stage    <= '0;
            rcvIdx   <= '0;
            dataDone <= 1'b0;
        end else begin
            dataDone <= 1'b0;
            if (rsp.valid) begin
                rcvIdx <= rcvIdx + 3'd1;
            end
            if (rdy) begin
                case (state)
                    seqIdle: begin
                        if (start) begin
                            state  <= seqIssue;
                            stage  <= '0;
                            rcvIdx <= '0;
                        end
                    end
                    seqIssue: begin
                        if (issued) begin
                            stage <= stage + 3'd1;
                            if (req.last && isStore) begin
                                // store ends on its final write
                                state    <= seqIdle;
                                dataDone <= 1'b1;
                            end else if (req.last) begin
                                state <= seqDrain;
                            end
                        end
                    end
                    seqDrain: begin
                        if (allIn) begin
                            state    <= seqIdle;
                            dataDone <= 1'b1;
                        end
                    end
                    default: state <= seqIdle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            baseAddr  <= dataAddr;
            lenReg    <= dataLen;
            isStore   <= dataStore;
            wdataReg  <= dataWdata;
            // zero fill for short loads
            dataRdata <= '0;
        end else if (rsp.valid) begin
            dataRdata[{rcvIdx[1:0], 3'b000} +: 8] <= rsp.rdata;
        end
    end

endmodule

/* rtl/memArbiter.sv */
`timescale 1ns/1ns

module memArbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  memctrl_pkg::ramReq_t fetchReq,
    input  memctrl_pkg::ramReq_t dataReq,
    output logic                 fetchGrant,
    output logic                 dataGrant,
    output memctrl_pkg::ramRsp_t fetchRsp,
    output memctrl_pkg::ramRsp_t dataRsp,
    output memctrl_pkg::addr_t   memAddr,
    output logic                 memWrite,
    output memctrl_pkg::byte_t   memWdata,
    input  memctrl_pkg::byte_t   memRdata
);
    import memctrl_pkg::*;

    owner_e  owner;
    owner_e  nextOwner;
    // who issued the read whose byte is on memRdata now
    owner_e  rdOwner;
    ramReq_t cur;
    logic    issue;

    assign fetchGrant = owner == ownFetch;
    assign dataGrant  = owner == ownData;

    always_comb begin
        case (owner)
            ownFetch: cur = fetchReq;
            ownData:  cur = dataReq;
            default:  cur = '0;
        endcase
    end

    assign issue    = cur.valid && rdy;
    assign memAddr  = cur.addr;
    assign memWdata = cur.wdata;
    assign memWrite = issue && cur.write;

    always_comb begin
        nextOwner = owner;
        case (owner)
            ownNone: begin
                // data side wins a tie
                if (dataReq.valid) begin
                    nextOwner = ownData;
                end else if (fetchReq.valid) begin
                    nextOwner = ownFetch;
                end
            end
            ownFetch, ownData: begin
                if (issue && cur.last) begin
                    nextOwner = ownNone;
                end
            end
            default: nextOwner = ownNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            owner   <= ownNone;
            rdOwner <= ownNone;
        end else begin
            if (rdy) begin
                owner <= nextOwner;
            end
            // follows every edge so a returning byte is never dropped
            if (issue && !cur.write) begin
                rdOwner <= owner;
            end else begin
                rdOwner <= ownNone;
            end
        end
    end

    always_comb begin
        fetchRsp.valid = rdOwner == ownFetch;
        fetchRsp.rdata = memRdata;
        dataRsp.valid  = rdOwner == ownData;
        dataRsp.rdata  = memRdata;
    end

endmodule

/* rtl/memCtrl.sv */
`timescale 1ns/1ns

module memCtrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic               ioBufferFull,
    input  logic               fetchEn,
    input  memctrl_pkg::addr_t fetchAddr,
    output logic               fetchDone,
    output memctrl_pkg::word_t fetchInst,
    input  logic               dataEn,
    input  logic               dataStore,
    input  memctrl_pkg::len_t  dataLen,
    input  memctrl_pkg::addr_t dataAddr,
    input  memctrl_pkg::word_t dataWdata,
    output logic               dataDone,
    output memctrl_pkg::word_t dataRdata,
    output memctrl_pkg::addr_t memAddr,
    output logic               memWrite,
    output memctrl_pkg::byte_t memWdata,
    input  memctrl_pkg::byte_t memRdata
);
    import memctrl_pkg::*;

    ramReq_t fetchReq;
    ramReq_t dataReq;
    ramRsp_t fetchRsp;
    ramRsp_t dataRsp;
    logic    fetchGrant;
    logic    dataGrant;

    fetchSeq u_fetchSeq (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .grant     (fetchGrant),
        .req       (fetchReq),
        .rsp       (fetchRsp)
    );

    dataSeq u_dataSeq (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .grant        (dataGrant),
        .req          (dataReq),
        .rsp          (dataRsp)
    );

    memArbiter u_memArbiter (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .fetchReq   (fetchReq),
        .dataReq    (dataReq),
        .fetchGrant (fetchGrant),
        .dataGrant  (dataGrant),
        .fetchRsp   (fetchRsp),
        .dataRsp    (dataRsp),
        .memAddr    (memAddr),
        .memWrite   (memWrite),
        .memWdata   (memWdata),
        .memRdata   (memRdata)
    );

endmodule

/* dv/memctrl_assert.sv */
`timescale 1ns/1ns

module memctrl_assert (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic memWrite,
    input logic fetchDone,
    input logic dataDone
);

    // RAM sees no write while the core is paused
    noWriteWhilePaused: assert property (@(posedge clk) !rdy |-> !memWrite)
        else $error("memWrite high while rdy low");

    doneLowAfterReset: assert property (@(posedge clk) rst |=> !fetchDone && !dataDone)
        else $error("done output high in the cycle after reset");

    fetchDoneOneCycle: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else $error("fetchDone held longer than one cycle");

    dataDoneOneCycle: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else $error("dataDone held longer than one cycle");

endmodule

bind memCtrl memctrl_assert u_memctrlAssert (
    .clk       (clk),
    .rst       (rst),
    .rdy       (rdy),
    .memWrite  (memWrite),
    .fetchDone (fetchDone),
    .dataDone  (dataDone)
);

/* dv/memctrl_tb.sv */
`timescale 1ns/1ns
`include "memctrl_cfg.svh"

module memctrl_tb;
    import memctrl_pkg::*;

    typedef logic [`MEMCTRL_RAM_AW-1:0] ramIdx_t;

    // one line of the vector file
    typedef struct packed {
        byte_t      op;
        addr_t      addr;
        len_t       len;
        word_t      wdata;
        word_t      expected;
        logic [1:0] stall;
    } vector_t;

    logic  clk = 1'b0;
    logic  rst;
    logic  rdy;
    logic  ioBufferFull;
    logic  fetchEn;
    addr_t fetchAddr;
    logic  fetchDone;
    word_t fetchInst;
    logic  dataEn;
    logic  dataStore;
    len_t  dataLen;
    addr_t dataAddr;
    word_t dataWdata;
    logic  dataDone;
    word_t dataRdata;
    addr_t memAddr;
    logic  memWrite;
    byte_t memWdata;
    byte_t memRdata = '0;

    byte_t   ram [0:(1 << `MEMCTRL_RAM_AW) - 1];
    byte_t   shadow [0:(1 << `MEMCTRL_RAM_AW) - 1];
    int      writeCount;
    vector_t vecs [$];
    string   names [$];
    int      errorCount = 0;
    int      failedTests = 0;
    bit      vectorsLoaded = 1'b0;

    memCtrl u_memCtrl (.*);

    always #20 clk = ~clk;

    function automatic byte_t fillByte(input ramIdx_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5A;
    endfunction

    // byte RAM, read data one cycle after the address
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `MEMCTRL_RAM_AW); i++) begin
                ram[ramIdx_t'(i)] <= fillByte(ramIdx_t'(i));
            end
            writeCount <= 0;
        end else if (memWrite) begin
            ram[ramIdx_t'(memAddr)] <= memWdata;
            writeCount <= writeCount + 1;
        end
        memRdata <= ram[ramIdx_t'(memAddr)];
    end

    function automatic word_t lenMask(input len_t len);
        case (len)
            3'd1: return 32'h0000_00ff;
            3'd2: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // little-endian word from the shadow copy, zero filled above len bytes
    function automatic word_t readShadow(input addr_t addr, input len_t len);
        word_t w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[8 * i +: 8] = shadow[ramIdx_t'(addr + addr_t'(i))];
        end
        return w;
    endfunction

    task automatic checkValue(input string what, input word_t expected,
                              input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", what, expected, actual);
            errorCount++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("FAIL %s", msg);
        errorCount++;
    endtask

    task automatic readVectors(output bit ok);
        int      fd;
        int      n;
        string   line;
        string   name;
        string   opStr;
        addr_t   a;
        word_t   w;
        word_t   e;
        int      l;
        int      s;
        vector_t v;
        ok = 1'b0;
        fd = $fopen("dv/memctrl_vectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %d %h %h %d", name, opStr, a, l, w, e, s);
                    if (n == 7) begin
                        v.op       = opStr.getc(0);
                        v.addr     = a;
                        v.len      = len_t'(l);
                        v.wdata    = w;
                        v.expected = e;
                        v.stall    = 2'(s);
                        names.push_back(name);
                        vecs.push_back(v);
                    end else begin
                        reportProblem({"malformed vector line: ", line});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runTest(input int idx);
        vector_t v;
        string   name;
        bit      isFetch;
        bit      isData;
        bit      fetchSeen;
        bit      dataSeen;
        int      cycles;
        int      fetchAt;
        int      dataAt;
        int      pausesLeft;
        int      pauseLen;
        int      holdCycles;
        int      writesBefore;
        int      errorsBefore;
        word_t   loadExp;
        v            = vecs[idx];
        name         = names[idx];
        isFetch      = v.op == "F" || v.op == "B";
        isData       = v.op != "F";
        fetchSeen    = 1'b0;
        dataSeen     = 1'b0;
        cycles       = 0;
        fetchAt      = 0;
        dataAt       = 0;
        pausesLeft   = 3;
        pauseLen     = 0;
        holdCycles   = 0;
        errorsBefore = errorCount;
        loadExp      = readShadow(v.addr, v.len);

        @(negedge clk);
        writesBefore = writeCount;
        fetchEn      = isFetch;
        fetchAddr    = v.addr;
        dataEn       = isData;
        dataStore    = v.op == "S";
        dataLen      = v.len;
        dataAddr     = v.addr;
        dataWdata    = v.wdata;
        if (v.stall == 2'd2) begin
            if (v.op != "S" || v.addr < `MEMCTRL_IO_BASE) begin
                reportProblem({name, ": IO stall test is not a store into the IO window"});
            end
            ioBufferFull = 1'b1;
            holdCycles   = $urandom_range(3, 8);
        end

        while ((isFetch && !fetchSeen) || (isData && !dataSeen)) begin
            @(negedge clk);
            cycles++;
            if (fetchEn && fetchDone) begin
                fetchSeen = 1'b1;
                fetchAt   = cycles;
                fetchEn   = 1'b0;
                checkValue({name, "/fetch"}, v.expected, fetchInst);
                checkValue({name, "/fetchShadow"},
                           readShadow(v.addr, len_t'(`MEMCTRL_FETCH_LEN)), fetchInst);
            end
            if (dataEn && dataDone) begin
                dataSeen = 1'b1;
                dataAt   = cycles;
                dataEn   = 1'b0;
                if (ioBufferFull) begin
                    reportProblem({name, ": store finished while the IO buffer was full"});
                end
                if (v.op != "S") begin
                    checkValue({name, "/load"}, v.expected & lenMask(v.len), dataRdata);
                    checkValue({name, "/loadShadow"}, loadExp, dataRdata);
                end
            end
            if (ioBufferFull && cycles >= holdCycles) begin
                checkValue({name, "/writesWhileFull"}, 32'd0,
                           word_t'(writeCount - writesBefore));
                ioBufferFull = 1'b0;
            end
            // short random pauses, at most three per test
            if (v.stall == 2'd1) begin
                if (pauseLen > 0) begin
                    rdy = 1'b0;
                    pauseLen--;
                end else if (pausesLeft > 0 && $urandom_range(0, 2) == 0) begin
                    rdy = 1'b0;
                    pausesLeft--;
                    pauseLen = $urandom_range(0, 2);
                end else begin
                    rdy = 1'b1;
                end
            end
        end
        rdy          = 1'b1;
        ioBufferFull = 1'b0;

        if (v.op == "S") begin
            for (int i = 0; i < int'(v.len); i++) begin
                shadow[ramIdx_t'(v.addr + addr_t'(i))] = v.wdata[8 * i +: 8];
                checkValue({name, "/ram"}, word_t'(shadow[ramIdx_t'(v.addr + addr_t'(i))]),
                           word_t'(ram[ramIdx_t'(v.addr + addr_t'(i))]));
            end
        end
        // latency from the first edge that samples the request
        if (v.stall == 2'd0) begin
            case (v.op)
                "F": checkValue({name, "/latency"}, 32'd6, word_t'(fetchAt - 1));
                "L": checkValue({name, "/latency"}, word_t'(v.len) + 32'd2,
                                word_t'(dataAt - 1));
                "S": checkValue({name, "/latency"}, word_t'(v.len) + 32'd1,
                                word_t'(dataAt - 1));
                default: ;
            endcase
        end
        if (v.op == "B" && dataAt >= fetchAt) begin
            reportProblem({name, ": dataDone did not come before fetchDone"});
        end

        if (errorCount == errorsBefore) begin
            $display("ok   %s  %0d cycles", name, cycles);
        end else begin
            $display("bad  %s  %0d failed checks", name, errorCount - errorsBefore);
            failedTests++;
        end
    endtask

    initial begin
        bit ok;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = '0;
        dataAddr     = '0;
        dataWdata    = '0;
        void'($urandom(21299));
        for (int i = 0; i < (1 << `MEMCTRL_RAM_AW); i++) begin
            shadow[ramIdx_t'(i)] = fillByte(ramIdx_t'(i));
        end
        readVectors(ok);
        if (!ok || vecs.size() == 0) begin
            $display("could not read any vectors from dv/memctrl_vectors.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            vectorsLoaded = 1'b1;
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (vecs[i]) begin
                runTest(i);
            end
            $display("%0d tests, %0d failed, %0d failed checks",
                     vecs.size(), failedTests, errorCount);
            if (errorCount == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        int limit;
        wait (vectorsLoaded);
        limit = vecs.size() * 40 + 100;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, a done pulse never arrived", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* memctrl.f */
+incdir+rtl
rtl/memctrl_pkg.sv
rtl/fetchSeq.sv
rtl/dataSeq.sv
rtl/memArbiter.sv
rtl/memCtrl.sv
dv/memctrl_assert.sv
dv/memctrl_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module memctrl_tb \
    -f memctrl.f \
    -o memctrlSim

status=0
./obj_dir/memctrlSim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi

/* dv/memctrl_vectors.txt */
# name op addr len wdata expected stall (addr, wdata and expected in hex)
# op F fetch, L load, S store, B fetch and load; stall 0 none, 1 rdy pauses, 2 IO buffer full
fetch0      F 00000000 4 00000000 59585b5a 0
fetch10     F 00000010 4 00000000 49484b4a 0
fetchRdy    F 00000024 4 00000000 7d7c7f7e 1
load1       L 00000005 1 00000000 0000005f 0
load2       L 00000006 2 00000000 00005d5c 0
load4       L 00000030 4 00000000 69686b6a 0
load4Rdy    L 00000041 4 00000000 1e19181b 1
store1      S 00000050 1 a5a5a5c3 00000000 0
check1      L 00000050 4 00000000 09080bc3 0
store2      S 00000060 2 1234beef 00000000 0
check2      L 00000060 4 00000000 3938beef 0
store4      S 00000070 4 cafef00d 00000000 0
check4      L 00000070 4 00000000 cafef00d 0
fetchStored F 00000070 4 00000000 cafef00d 0
store2Rdy   S 00000082 2 00007788 00000000 1
check2Rdy   L 00000080 4 00000000 7788dbda 0
both1       B 00000090 1 00000000 c9c8cbca 0
both4       B 000000a4 4 00000000 fdfcfffe 0
both2Rdy    B 000000b8 2 00000000 e1e0e3e2 1
ioStore4    S 00030040 4 44332211 00000000 2
ioCheck4    L 00030040 4 00000000 44332211 0
ioStore1    S 000300c1 1 000000e7 00000000 2
ioCheck1    L 000300c0 2 00000000 0000e79a 0
